/* flist.f */
+incdir+testbench
hw/axiLitePkg.sv
hw/regStorePkg.sv
hw/channelCapture.sv
hw/accessArbiter.sv
hw/regStore.sv
hw/axiLiteRegs.sv
testbench/tbAxiLiteRegs.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the register window testbench with Verilator and runs it.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

buildDir="build"
logFile="sim.log"
simBinary="simTb"
passMessage="Simulation finished: PASS"

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found on PATH"
    exit 1
fi

rm -rf "$buildDir"
verilator --binary --timing --assert \
    -f flist.f \
    --top-module tbAxiLiteRegs \
    -Mdir "$buildDir" -o "$simBinary"
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -qxF "$passMessage" "$logFile" && [ "$runStatus" -eq 0 ]; then
    echo "run passed"
    exit 0
else
    echo "run failed with status $runStatus"
    exit 1
fi

/* testbench/tbChecks.svh */
// Testbench compare tasks
`ifndef tbChecksSvh
`define tbChecksSvh

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fail path.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// every failure ends the run here, once its reason has been printed.
task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first failure");
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// value compares, one per kind of result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// write responses carry only a response code.
task automatic checkResp(
    input string name,
    input axiLitePkg::respT got,
    input axiLitePkg::respT expected
);
    if (got !== expected) begin
        failRun($sformatf("Error at time %0t: %s is %0d, expected %0d",
                          $time, name, got, expected));
    end
endtask

// read responses carry a full data word.
// The case compare also catches unknown bits from an unwritten word.
task automatic checkData(
    input string name,
    input axiLitePkg::dataT got,
    input axiLitePkg::dataT expected
);
    if (got !== expected) begin
        failRun($sformatf("Error at time %0t: %s is %h, expected %h",
                          $time, name, got, expected));
    end
endtask

`endif

/* testbench/tbAxiLiteRegs.sv */
// AXI4-Lite register window testbench
module tbAxiLiteRegs;

    localparam int halfPeriod = 4;
    localparam int resetCycles = 16;
    localparam int randomSeed = 45394;
    // the store answers for 64 words, so byte addresses 256 apart alias.
    localparam int modelWords = 64;
    localparam int randomCount = 200;
    // preload, the directed accesses and the random run.
    localparam int numTransactions = modelWords + 11 + randomCount;
    localparam int cyclesPerTransaction = 40;

    // what the model predicts for one access.
    typedef struct packed {
        axiLitePkg::respT resp;
        axiLitePkg::dataT data;
    } expectT;

    logic clock;
    logic rstN;
    logic awValid;
    logic awReady;
    axiLitePkg::awChanT aw;
    logic wValid;
    logic wReady;
    axiLitePkg::wChanT w;
    logic bValid;
    logic bReady;
    axiLitePkg::respT bResp;
    logic arValid;
    logic arReady;
    axiLitePkg::arChanT ar;
    logic rValid;
    logic rReady;
    axiLitePkg::dataT rData;

    // model memory and the responses still owed by the DUT, in order.
    axiLitePkg::dataT modelMem [modelWords];
    axiLitePkg::respT expResp [$];
    axiLitePkg::dataT expData [$];
    logic stallReady = 1'b0;

    // a response seen last edge but not yet accepted.
    logic bWaiting = 1'b0;
    logic rWaiting = 1'b0;
    axiLitePkg::respT bHeldResp;
    axiLitePkg::dataT rHeldData;

    `include "tbChecks.svh"

    axiLiteRegs dut (
        .clock(clock), .rstN(rstN),
        .awValid(awValid), .awReady(awReady), .aw(aw),
        .wValid(wValid), .wReady(wReady), .w(w),
        .bValid(bValid), .bReady(bReady), .bResp(bResp),
        .arValid(arValid), .arReady(arReady), .ar(ar),
        .rValid(rValid), .rReady(rReady), .rData(rData)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a write lands only with all four strobes set, otherwise it is refused
    // with SLVERR and the word keeps its value.
    // A read returns the word at its aliased index.
    function automatic expectT modelAccess(
        input logic isWrite,
        input axiLitePkg::byteAddrT addr,
        input axiLitePkg::dataT data,
        input axiLitePkg::strbT strb
    );
        expectT result;
        logic [5:0] wordIndex;
        wordIndex = 6'((int'(addr) / 4) % modelWords);
        result.resp = 2'd0;
        result.data = modelMem[wordIndex];
        if (isWrite) begin
            if (strb == 4'hF) begin
                modelMem[wordIndex] = data;
            end else begin
                result.resp = 2'd2;
            end
        end
        return result;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock, watchdog and response ready.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    // each access gets a generous cycle budget, even under stalls.
    initial begin
        #((numTransactions * cyclesPerTransaction + resetCycles) * 2 * halfPeriod);
        failRun("The run timed out before all accesses had completed.");
    end

    // ready is always high unless the stall phase is on.
    initial begin
        bReady = 1'b1;
        rReady = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            if (stallReady) begin
                bReady = ($urandom % 3) != 0;
                rReady = ($urandom % 3) != 0;
            end else begin
                bReady = 1'b1;
                rReady = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comparing process.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clock) begin
        if (rstN) begin
            // a stalled response must stay offered and unchanged.
            if (bWaiting) begin
                if (!bValid) begin
                    failRun("bValid dropped before the write response was accepted.");
                end else begin
                    checkResp("bResp", bResp, bHeldResp);
                end
            end
            if (rWaiting) begin
                if (!rValid) begin
                    failRun("rValid dropped before the read response was accepted.");
                end else begin
                    checkData("rData", rData, rHeldData);
                end
            end
            if (bValid && bReady) begin
                if (expResp.size() == 0) begin
                    failRun("The DUT sent a write response that no write was waiting for.");
                end else begin
                    checkResp("bResp", bResp, expResp.pop_front());
                end
            end
            if (rValid && rReady) begin
                if (expData.size() == 0) begin
                    failRun("The DUT sent a read response that no read was waiting for.");
                end else begin
                    checkData("rData", rData, expData.pop_front());
                end
            end
            bWaiting = bValid && !bReady;
            rWaiting = rValid && !rReady;
            bHeldResp = bResp;
            rHeldData = rData;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // offers the chosen request beats together and drops each valid once
    // its own handshake has happened.
    task automatic driveChannels(
        input logic doWrite,
        input logic doRead,
        input axiLitePkg::byteAddrT addr,
        input axiLitePkg::dataT data,
        input axiLitePkg::strbT strb
    );
        logic awDone;
        logic wDone;
        logic arDone;
        awDone = !doWrite;
        wDone = !doWrite;
        arDone = !doRead;
        aw.addr = addr;
        w.data = data;
        w.strb = strb;
        ar.addr = addr;
        awValid = doWrite;
        wValid = doWrite;
        arValid = doRead;
        while (!(awDone && wDone && arDone)) begin
            @(posedge clock);
            if (awValid && awReady) begin
                awDone = 1'b1;
            end
            if (wValid && wReady) begin
                wDone = 1'b1;
            end
            if (arValid && arReady) begin
                arDone = 1'b1;
            end
            #1;
            awValid = !awDone;
            wValid = !wDone;
            arValid = !arDone;
        end
    endtask

    task automatic issueWrite(
        input axiLitePkg::byteAddrT addr,
        input axiLitePkg::dataT data,
        input axiLitePkg::strbT strb
    );
        expectT expected;
        expected = modelAccess(1'b1, addr, data, strb);
        expResp.push_back(expected.resp);
        driveChannels(1'b1, 1'b0, addr, data, strb);
    endtask

    task automatic issueRead(input axiLitePkg::byteAddrT addr);
        expectT expected;
        expected = modelAccess(1'b0, addr, '0, '0);
        expData.push_back(expected.data);
        driveChannels(1'b0, 1'b1, addr, '0, '0);
    endtask

    // AW, W and AR in one cycle from idle, where the write goes first.
    task automatic collideAccess(
        input axiLitePkg::byteAddrT addr,
        input axiLitePkg::dataT data
    );
        expectT writeExpected;
        expectT readExpected;
        writeExpected = modelAccess(1'b1, addr, data, 4'hF);
        readExpected = modelAccess(1'b0, addr, '0, '0);
        expResp.push_back(writeExpected.resp);
        expData.push_back(readExpected.data);
        driveChannels(1'b1, 1'b1, addr, data, 4'hF);
    endtask

    // returns one unit after an edge once every owed response has come back.
    task automatic waitResponses();
        do begin
            @(posedge clock);
            #1;
        end while (expResp.size() != 0 || expData.size() != 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        axiLitePkg::byteAddrT addr;
        axiLitePkg::strbT strb;
        void'($urandom(randomSeed));
        rstN = 1'b0;
        awValid = 1'b0;
        wValid = 1'b0;
        arValid = 1'b0;
        aw = '0;
        w = '0;
        ar = '0;
        repeat (resetCycles) @(posedge clock);
        #1;
        rstN = 1'b1;
        if (!(awReady && wReady && arReady) || bValid || rValid) begin
            failRun("The DUT did not leave reset idle with all request channels ready.");
        end

        // every word gets a known value first, since the store is not reset.
        for (int i = 0; i < modelWords; i++) begin
            addr = axiLitePkg::byteAddrT'(i * 4);
            issueWrite(addr, {16'hC0DE ^ {1'b0, addr}, ~{1'b0, addr}}, 4'hF);
            waitResponses();
        end

        issueWrite(15'h0010, 32'hDEADBEEF, 4'hF);
        waitResponses();
        issueRead(15'h0010);
        waitResponses();

        // a partial write is refused and leaves the old word in place.
        issueWrite(15'h0024, 32'h11112222, 4'hF);
        waitResponses();
        issueWrite(15'h0024, 32'h33334444, 4'b0111);
        waitResponses();
        issueRead(15'h0024);
        waitResponses();

        issueWrite(15'h0040, 32'h5A5A0F0F, 4'hF);
        waitResponses();
        issueRead(15'h0140);
        waitResponses();

        // each collision follows a read, so the turn goes to the write and
        // the read sees the new word.
        collideAccess(15'h0080, 32'hC0111DE1);
        waitResponses();
        collideAccess(15'h0080, 32'hC0111DE2);
        waitResponses();

        stallReady = 1'b1;
        for (int i = 0; i < randomCount; i++) begin
            addr = axiLitePkg::byteAddrT'($urandom);
            strb = 4'hF;
            if ($urandom % 4 == 0) begin
                strb = axiLitePkg::strbT'($urandom);
            end
            if ($urandom % 2 == 0) begin
                issueWrite(addr, axiLitePkg::dataT'($urandom), strb);
            end else begin
                issueRead(addr);
            end
            waitResponses();
        end
        stallReady = 1'b0;

        // once the last response is taken the DUT is idle again.
        if (!bValid && !rValid && awReady && wReady && arReady) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            failRun("The DUT did not return to idle after the last response.");
        end
    end

endmodule

/* hw/axiLiteRegs.sv */
// AXI4-Lite register window
module axiLiteRegs (
    input logic clock,
    input logic rstN,
    input logic awValid,
    output logic awReady,
    input axiLitePkg::awChanT aw,
    input logic wValid,
    output logic wReady,
    input axiLitePkg::wChanT w,
    output logic bValid,
    input logic bReady,
    output axiLitePkg::respT bResp,
    input logic arValid,
    output logic arReady,
    input axiLitePkg::arChanT ar,
    output logic rValid,
    input logic rReady,
    output axiLitePkg::dataT rData
);

    // beats waiting in the capture stages.
    logic awHeld;
    logic wHeld;
    logic arHeld;
    axiLitePkg::awChanT awStaged;
    axiLitePkg::wChanT wStaged;
    axiLitePkg::arChanT arStaged;

    // consume strobes from the arbiter.
    // One write take empties both the AW and the W stage.
    logic takeWrite;
    logic takeRead;

    // arbiter to store.
    logic opValid;
    regStorePkg::storeOpT op;
    logic readRespValid;
    axiLitePkg::dataT readData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request channel captures.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    channelCapture #(.payloadT(axiLitePkg::awChanT)) awCapture (
        .clock(clock), .rstN(rstN),
        .valid(awValid), .ready(awReady), .payloadIn(aw),
        .take(takeWrite), .held(awHeld), .payload(awStaged)
    );

    channelCapture #(.payloadT(axiLitePkg::wChanT)) wCapture (
        .clock(clock), .rstN(rstN),
        .valid(wValid), .ready(wReady), .payloadIn(w),
        .take(takeWrite), .held(wHeld), .payload(wStaged)
    );

    channelCapture #(.payloadT(axiLitePkg::arChanT)) arCapture (
        .clock(clock), .rstN(rstN),
        .valid(arValid), .ready(arReady), .payloadIn(ar),
        .take(takeRead), .held(arHeld), .payload(arStaged)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arbitration and storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    accessArbiter arbiter (
        .clock(clock), .rstN(rstN),
        .awHeld(awHeld), .wHeld(wHeld), .arHeld(arHeld),
        .aw(awStaged), .w(wStaged), .ar(arStaged),
        .takeWrite(takeWrite), .takeRead(takeRead),
        .opValid(opValid), .op(op),
        .readRespValid(readRespValid), .readData(readData),
        .bValid(bValid), .bReady(bReady), .bResp(bResp),
        .rValid(rValid), .rReady(rReady), .rData(rData)
    );

    regStore store (
        .clock(clock), .rstN(rstN),
        .opValid(opValid), .op(op),
        .readRespValid(readRespValid), .readData(readData)
    );

endmodule

/* hw/regStore.sv */
// Word-addressed register store
module regStore (
    input logic clock,
    input logic rstN,
    input logic opValid,
    input regStorePkg::storeOpT op,
    output logic readRespValid,
    output axiLitePkg::dataT readData
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the words start with unknown contents after power-up.
    axiLitePkg::dataT mem [regStorePkg::storeDepth];

    // entry selected by the op.
    // The upper word address bits are ignored, which gives the aliasing.
    logic [regStorePkg::storeIndexW-1:0] index;

    logic doWrite;
    logic doRead;

    assign index = op.wordAddr[regStorePkg::storeIndexW-1:0];
    assign doWrite = opValid && op.enWrite;
    assign doRead = opValid && !op.enWrite;

    // a write lands on the edge that ends its op cycle.
    // A read on that same edge samples the stored word into readData.
    always_ff @(posedge clock) begin
        if (doWrite) begin
            mem[index] <= op.writeData;
        end
        if (doRead) begin
            readData <= mem[index];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read response strobe.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the store never stalls, so each read op produces exactly one pulse
    // in the following cycle.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            readRespValid <= 1'b0;
        end else begin
            readRespValid <= doRead;
        end
    end

    // the arbiter holds further ops back until a read has answered.
    readAnswersAlone: assert property (
        @(posedge clock) disable iff (!rstN)
        doRead |=> !opValid
    );

endmodule

/* hw/accessArbiter.sv */
// Read/write access arbiter
module accessArbiter (
    input logic clock,
    input logic rstN,
    input logic awHeld,
    input logic wHeld,
    input logic arHeld,
    input axiLitePkg::awChanT aw,
    input axiLitePkg::wChanT w,
    input axiLitePkg::arChanT ar,
    output logic takeWrite,
    output logic takeRead,
    output logic opValid,
    output regStorePkg::storeOpT op,
    input logic readRespValid,
    input axiLitePkg::dataT readData,
    output logic bValid,
    input logic bReady,
    output axiLitePkg::respT bResp,
    output logic rValid,
    input logic rReady,
    output axiLitePkg::dataT rData
);

    // state of the single response slot.
    logic slotFull;
    // kind of the last advanced access, and of the response in the slot.
    logic lastWrite;
    logic deniedWrite;

    logic writeComplete;
    logic selWrite;
    logic selRead;
    logic readInFlight;
    logic drainResp;
    logic canAdvance;
    logic advanceWrite;
    logic advanceRead;
    logic fullStrobe;
    logic issueOp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // selection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a write can only go once both its address and its data are here.
    assign writeComplete = awHeld && wHeld;

    // when both kinds wait, the turn goes to the kind that did not advance
    // last time.
    // lastWrite comes out of reset low, so the first contest goes to the write.
    assign selWrite = writeComplete && (!arHeld || !lastWrite);
    assign selRead = arHeld && (!writeComplete || lastWrite);

    // a read occupies the store from its op until its data comes back.
    // Nothing may advance in that window, because the returning data
    // fills the slot.
    assign readInFlight = (opValid && !op.enWrite) || readRespValid;

    // the slot drains on the ready of whichever channel it currently feeds.
    assign drainResp = lastWrite ? bReady : rReady;

    assign canAdvance = !readInFlight && (!slotFull || drainResp);
    assign advanceWrite = canAdvance && selWrite;
    assign advanceRead = canAdvance && selRead;

    // partial writes are refused, and only a write with every lane enabled
    // reaches the store.
    assign fullStrobe = &w.strb;
    assign issueOp = (advanceWrite && fullStrobe) || advanceRead;

    // the write consumes both the address and the data stage.
    assign takeWrite = advanceWrite;
    assign takeRead = advanceRead;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // op issue and slot control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a write response is ready at once, because the store always accepts
    // the op.
    // A read response waits for the data pulse from the store.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            opValid <= 1'b0;
            lastWrite <= 1'b0;
            slotFull <= 1'b0;
        end else begin
            opValid <= issueOp;
            if (advanceWrite || advanceRead) begin
                lastWrite <= advanceWrite;
            end
            slotFull <= advanceWrite || readRespValid || (slotFull && !drainResp);
        end
    end

    // the op word is taken from whichever capture won this edge.
    always_ff @(posedge clock) begin
        if (issueOp) begin
            op.enWrite <= advanceWrite;
            op.wordAddr <= advanceWrite ? aw.addr[axiLitePkg::addrW-1:2]
                                        : ar.addr[axiLitePkg::addrW-1:2];
            op.writeData <= w.data;
        end
    end

    // response payload.
    // deniedWrite is only looked at while a write response is in the slot.
    always_ff @(posedge clock) begin
        if (advanceWrite || advanceRead) begin
            deniedWrite <= advanceWrite && !fullStrobe;
        end
        if (readRespValid) begin
            rData <= readData;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response channels.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the one slot is steered to B or R by the kind that filled it.
    assign bValid = slotFull && lastWrite;
    assign rValid = slotFull && !lastWrite;
    assign bResp = deniedWrite ? axiLitePkg::respSlvErr : axiLitePkg::respOkay;

    // only one access can leave the captures on any edge.
    oneTakePerEdge: assert property (
        @(posedge clock) disable iff (!rstN)
        !(takeWrite && takeRead)
    );

    // one response at a time, on exactly one of the two channels.
    oneResponse: assert property (
        @(posedge clock) disable iff (!rstN)
        !(bValid && rValid)
    );

endmodule

/* hw/channelCapture.sv */
// One-entry channel holding stage
module channelCapture #(
    parameter type payloadT = logic
) (
    input logic clock,
    input logic rstN,
    input logic valid,
    output logic ready,
    input payloadT payloadIn,
    input logic take,
    output logic held,
    output payloadT payload
);

    // a beat transfers when the outside offers one and the stage is empty.
    logic accept;

    // the stage is ready exactly when it holds nothing, so at most one
    // beat ever waits here for the arbiter.
    assign ready = !held;
    assign accept = valid && ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // occupancy and payload.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the held flag sets on a transfer and clears when the arbiter takes
    // the beat.
    // accept and take can't meet on one edge, since take needs held.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            held <= 1'b0;
        end else begin
            held <= accept || (held && !take);
        end
    end

    // the payload only loads on a transfer and stays put while held.
    always_ff @(posedge clock) begin
        if (accept) begin
            payload <= payloadIn;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake rules with the arbiter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the arbiter only consumes a beat that is actually here.
    takeNeedsHeld: assert property (
        @(posedge clock) disable iff (!rstN)
        take |-> held
    );

    // a held beat stays until the arbiter takes it.
    heldUntilTake: assert property (
        @(posedge clock) disable iff (!rstN)
        held && !take |=> held
    );

endmodule

/* hw/regStorePkg.sv */
// Register store operation types
package regStorePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // addressing of the store.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a word address is the byte address without its two lane bits.
    localparam int wordAddrW = axiLitePkg::addrW - 2;

    // only the low index bits select a word, so higher word addresses
    // alias onto the same 64 entries.
    localparam int storeIndexW = 6;
    localparam int storeDepth = 64;

    typedef logic [wordAddrW-1:0] wordAddrT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one operation issued by the arbiter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // enWrite selects a write, otherwise the op is a read.
    // writeData is meaningful for writes only.
    typedef struct packed {
        logic enWrite;
        wordAddrT wordAddr;
        axiLitePkg::dataT writeData;
    } storeOpT;

endpackage

/* hw/axiLitePkg.sv */
// AXI4-Lite channel types
package axiLitePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths of the subordinate port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the register window spans 32 KiB of byte address space.
    localparam int addrW = 15;
    localparam int dataW = 32;
    // one strobe bit per byte lane of the data word.
    localparam int strbW = dataW / 8;

    typedef logic [addrW-1:0] byteAddrT;
    typedef logic [dataW-1:0] dataT;
    typedef logic [strbW-1:0] strbT;
    typedef logic [1:0] respT;

    // only two response codes are ever returned by this port.
    localparam respT respOkay = 2'd0;
    localparam respT respSlvErr = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // channel payloads, one struct per request channel.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // write address beat.
    typedef struct packed {
        byteAddrT addr;
    } awChanT;

    // write data beat with its byte strobes.
    typedef struct packed {
        dataT data;
        strbT strb;
    } wChanT;

    // read address beat.
    typedef struct packed {
        byteAddrT addr;
    } arChanT;

endpackage
